//--- piir_top.f
verilog/piir_pkg.sv
verilog/piir_regs.sv
verilog/piir_mac.sv
verilog/piir_ctrl.sv
verilog/piir_top.sv
verification/piir_tb.sv

//--- run_sim.sh
#!/bin/sh
# build the biquad testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module piir_tb \
  -f piir_top.f --Mdir obj_dir -o piir_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/piir_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "^RESULT: PASS$" sim.log; then
  echo "simulation passed"
  exit 0
fi
echo "simulation failed"
exit 1

//--- verification/piir_tb.sv
// Testbench for the biquad IIR peripheral (piir_top).
// Loads every register with cfg high, then runs frames of random samples.
// A sign-magnitude model predicts each output, and a comparing process
// checks ad_out on every ale, wr and idle cycle.
// Covers reset, first frame, steady state, pause and a ce stall.

`timescale 1ns/1ps
`default_nettype none

module piir_tb;

  logic          clk = 1'b0;
  logic          rst, ce, cfg, pu;
  logic [3:0]    cfg_sel;
  piir_pkg::sm_t ad_in, ad_out;
  logic          ale, rd, wr;

  // model state, a1/a2 kept as written (not negated)
  logic [15:0] m_a1, m_a2, m_b0, m_b1, m_b2;
  logic [15:0] m_x, m_x1, m_x2, m_y1, m_y2;
  logic [15:0] m_dev;
  logic [15:0] exp_y;        // expected y of the frame in flight
  logic        exp_valid;
  logic        first_frame;  // model twin of the DUT flag

  int cyc     = 0;
  int seq_err = 0;  // errors from the main sequence
  int seq_chk = 0;
  int cmp_err = 0;  // errors from the comparing process
  int cmp_chk = 0;
  int n_pass  = 0;
  int n_fail  = 0;

  piir_top dut_i (
    .clk(clk), .rst(rst), .ce(ce), .cfg(cfg), .pu(pu), .cfg_sel(cfg_sel),
    .ad_in(ad_in), .ad_out(ad_out), .ale(ale), .rd(rd), .wr(wr)
  );

  always #2 clk = ~clk;  // 4 ns period

  always @(posedge clk) cyc <= cyc + 1;

  // Q0.15 product, keep the top 15 bits of 30
  function automatic logic [15:0] mul_sm(input logic [15:0] a, input logic [15:0] b);
    logic [29:0] p;
    p = 30'(a[14:0]) * 30'(b[14:0]);
    return {a[15] ^ b[15], p[29:15]};
  endfunction

  function automatic logic [15:0] add_sm(input logic [15:0] a, input logic [15:0] b);
    logic [14:0] s;
    if (a[15] == b[15]) begin
      s = a[14:0] + b[14:0];  // wraps at 2^15
      return {a[15], s};
    end
    if (a[14:0] > b[14:0])
      return {a[15], a[14:0] - b[14:0]};
    if (b[14:0] > a[14:0])
      return {b[15], b[14:0] - a[14:0]};
    return 16'h0000;  // exact cancel gives +0
  endfunction

  // y = b0 x + b1 x1 + b2 x2 - a1 y1 - a2 y2, summed in MAC order
  function automatic logic [15:0] model_output();
    logic [15:0] acc;
    acc = 16'h0000;
    acc = add_sm(acc, mul_sm(m_a1 ^ 16'h8000, m_y1));  // feedback negated
    acc = add_sm(acc, mul_sm(m_a2 ^ 16'h8000, m_y2));
    acc = add_sm(acc, mul_sm(m_b1, m_x1));
    acc = add_sm(acc, mul_sm(m_b2, m_x2));
    acc = add_sm(acc, mul_sm(m_b0, m_x));
    return acc;
  endfunction

  // new sample read; history only moves after the first frame
  task automatic absorb_sample(input logic [15:0] s);
    if (first_frame) begin
      first_frame = 1'b0;  // preloaded history used as is
    end else begin
      m_y2 = m_y1;
      m_y1 = exp_y;        // last frame's output
      m_x2 = m_x1;
      m_x1 = m_x;
      m_x  = s;
    end
    exp_y     = model_output();
    exp_valid = 1'b1;
  endtask

  // one clock; put a fresh sample up for rd when ale is seen
  task automatic tick();
    logic [15:0] s;
    @(posedge clk);
    if (!rst && ce && ale) begin
      s = 16'($urandom);
      ad_in <= s;
      absorb_sample(s);
    end
  endtask

  task automatic end_run();
    int errs;
    errs = seq_err + cmp_err;
    $display("tests passed %0d, failed %0d, checks %0d, errors %0d",
             n_pass, n_fail, seq_chk + cmp_chk, errs);
    if (errs == 0)
      $display("RESULT: PASS");
    else
      $display("RESULT: FAIL");
    $finish;
  endtask

  // which: 0 ale, 1 rd, 2 wr; at returns the cycle it was seen
  task automatic wait_for(input string name, input int which, output int at);
    int          n;
    logic        hit;
    logic [2:0]  st;
    n   = 0;
    hit = 1'b0;
    while (!hit && n < 200) begin
      tick();
      n++;
      st  = {wr, rd, ale};
      hit = ce && st[which];
    end
    at = cyc;
    if (!hit) begin
      $display("timeout: no %s strobe seen within 200 cycles", name);
      seq_err++;
      end_run();
    end
  endtask

  task automatic check_quiet(input string where);
    seq_chk++;
    if (ale || rd || wr) begin
      $display("Error: {ale,rd,wr} = %h during %s, expected 0", {ale, rd, wr}, where);
      seq_err++;
    end
  endtask

  task automatic finish_test(input string name, input int errs_before);
    int now_err;
    @(negedge clk);  // comparator has settled this edge
    now_err = seq_err + cmp_err;
    if (now_err == errs_before) begin
      n_pass++;
      $display("test %s: ok", name);
    end else begin
      n_fail++;
      $display("test %s: %0d errors", name, now_err - errs_before);
    end
  endtask

  // every select code once, unused ones too; dev last
  task automatic configure();
    logic [15:0] v;
    exp_valid   = 1'b0;
    first_frame = 1'b1;
    cfg <= 1'b1;
    for (int code = 0; code < 16; code++) begin
      v = (code == 15) ? 16'h998d : 16'($urandom);
      tick();
      check_quiet("configure");
      cfg_sel <= 4'(code);
      ad_in   <= v;
      case (code)
        1:  m_a1  = v;
        2:  m_a2  = v;
        5:  m_y1  = v;
        6:  m_y2  = v;
        8:  m_b0  = v;
        9:  m_b1  = v;
        10: m_b2  = v;
        12: m_x   = v;
        13: m_x1  = v;
        14: m_x2  = v;
        15: m_dev = v;
        default: ;  // gap codes, DUT must ignore
      endcase
    end
    tick();  // dev write lands here
    check_quiet("configure");
    cfg     <= 1'b0;
    cfg_sel <= 4'd0;
  endtask

  // comparing process, one look per enabled edge
  always @(posedge clk) begin
    if (!rst && ce) begin
      cmp_chk++;
      if (ale) begin
        if (ad_out !== m_dev) begin
          $display("Error: ad_out = %h on ale, expected dev_addr %h", ad_out, m_dev);
          cmp_err++;
        end
      end else if (wr) begin
        if (!exp_valid) begin
          $display("wr strobe seen with no frame started since configuration");
          cmp_err++;
        end else if (ad_out !== exp_y) begin
          $display("Error: ad_out = %h on wr, expected y %h", ad_out, exp_y);
          cmp_err++;
        end
      end else if (ad_out !== 16'h0000) begin
        $display("Error: ad_out = %h with no strobe, expected 0000", ad_out);
        cmp_err++;
      end
    end
  end

  initial begin
    int errs0;
    int t_ale;
    int t_prev;
    int t_wr;
    void'($urandom(2570));
    rst = 1'b1; ce = 1'b1; cfg = 1'b1; pu = 1'b0;
    cfg_sel = 4'd0;
    ad_in   = '0;
    {m_a1, m_a2, m_b0, m_b1, m_b2} = '0;
    {m_x, m_x1, m_x2, m_y1, m_y2}  = '0;
    m_dev = '0; exp_y = '0; exp_valid = 1'b0; first_frame = 1'b1;

    // reset, 5 cycles, strobes must stay low
    errs0 = 0;
    for (int i = 0; i < 5; i++) begin
      tick();
      if (i > 0)
        check_quiet("reset");
    end
    rst <= 1'b0;
    configure();
    finish_test("reset_config", errs0);

    errs0 = seq_err + cmp_err;
    wait_for("ale", 0, t_ale);  // comparator checks dev_addr
    finish_test("dev_addr", errs0);

    errs0 = seq_err + cmp_err;
    wait_for("wr", 2, t_wr);    // from preloaded history
    finish_test("first_frame", errs0);

    errs0  = seq_err + cmp_err;
    t_prev = t_ale;
    for (int f = 0; f < 20; f++) begin
      wait_for("ale", 0, t_ale);
      seq_chk++;
      if (t_ale - t_prev != 10) begin
        $display("Error: ale spacing = %h cycles, expected %h", t_ale - t_prev, 10);
        seq_err++;
      end
      t_prev = t_ale;
      wait_for("wr", 2, t_wr);
      // ale, rd, seven math cycles, then wr
      seq_chk++;
      if (t_wr - t_ale != 9) begin
        $display("Error: wr delay after ale = %h cycles, expected %h", t_wr - t_ale, 9);
        seq_err++;
      end
    end
    finish_test("steady_state", errs0);

    // pu up during math, so the frame ends in pause
    errs0 = seq_err + cmp_err;
    wait_for("rd", 1, t_wr);
    pu <= 1'b1;
    wait_for("wr", 2, t_wr);
    for (int i = 0; i < 30; i++) begin
      tick();
      check_quiet("pause");
    end
    pu <= 1'b0;
    wait_for("wr", 2, t_wr);
    wait_for("wr", 2, t_wr);
    finish_test("pause", errs0);

    // stall right in the rd cycle, rd must stay up
    errs0 = seq_err + cmp_err;
    wait_for("ale", 0, t_ale);
    ce <= 1'b0;
    for (int i = 0; i < 12; i++) begin
      tick();
      seq_chk++;
      if ({ale, rd, wr} !== 3'b010) begin
        $display("Error: {ale,rd,wr} = %h during stall, expected 2", {ale, rd, wr});
        seq_err++;
      end
    end
    ce <= 1'b1;
    wait_for("wr", 2, t_wr);
    wait_for("wr", 2, t_wr);
    finish_test("stall", errs0);

    end_run();
  end

endmodule

`default_nettype wire

//--- verilog/piir_ctrl.sv
// Frame FSM of the biquad.
// Runs ale -> read -> math -> write, ten cycles per frame, and parks in
// pause between frames while pu is high. Strobes are registered off the
// next state, so they line up with the state they belong to.
// Holds the output y, latched on entry to write, and the first-frame flag
// that keeps the history unshifted on the first frame after config.

`timescale 1ns/1ps
`default_nettype none

module piir_ctrl (
  input  logic           clk,
  input  logic           rst,
  input  logic           ce,
  input  logic           cfg,
  input  logic           pu,        // pause at frame end
  input  logic           mac_done,
  input  piir_pkg::sm_t  acc,
  output logic           ale,
  output logic           rd,
  output logic           wr,
  output logic           shift,     // history push request
  output logic           mac_start,
  output piir_pkg::sm_t  y
);

  piir_pkg::frame_state_e state, nxt;
  logic                   first;    // set by config, cleared after first read

  // next state
  always_comb begin
    nxt = state;
    if (cfg) begin
      nxt = piir_pkg::cfg_st;        // config wins from any state
    end else begin
      case (state)
        piir_pkg::cfg_st:   nxt = piir_pkg::ale_st;
        piir_pkg::ale_st:   nxt = piir_pkg::read_st;
        piir_pkg::read_st:  nxt = piir_pkg::math_st;
        piir_pkg::math_st:  if (mac_done) nxt = piir_pkg::write_st;
        piir_pkg::write_st: nxt = pu ? piir_pkg::pause_st : piir_pkg::ale_st;
        piir_pkg::pause_st: if (!pu) nxt = piir_pkg::ale_st;
        default:            nxt = piir_pkg::cfg_st;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state     <= piir_pkg::cfg_st;
      first     <= 1'b1;
      ale       <= 1'b0;
      rd        <= 1'b0;
      wr        <= 1'b0;
      shift     <= 1'b0;
      mac_start <= 1'b0;
      y         <= '0;
    end else if (ce) begin
      state     <= nxt;
      ale       <= (nxt == piir_pkg::ale_st);
      rd        <= (nxt == piir_pkg::read_st);
      wr        <= (nxt == piir_pkg::write_st);
      // push history on every read but the first after config
      shift     <= (nxt == piir_pkg::read_st) && !first;
      // first math cycle only
      mac_start <= (nxt == piir_pkg::math_st) && (state == piir_pkg::read_st);

      if (cfg)
        first <= 1'b1;
      else if (state == piir_pkg::read_st)
        first <= 1'b0;                // first read done

      // result goes out with wr
      if (state == piir_pkg::math_st && nxt == piir_pkg::write_st)
        y <= acc;
    end
  end

  // MAC result may only come back while the frame is in math
  a_done_in_math : assert property (
    @(posedge clk) disable iff (rst)
    (ce && mac_done) |-> (state == piir_pkg::math_st)
  ) else $error("mac done outside the math state");

endmodule

`default_nettype wire

//--- verilog/piir_mac.sv
// Shared multiply-accumulate unit for the biquad.
// A start pulse clears the accumulator; the next five cycles each fold one
// coefficient x history product into it, order a1*y1, a2*y2, b1*x1,
// b2*x2, b0*x. done pulses one cycle after the last step with acc valid.
// All arithmetic is sign-magnitude Q0.15; magnitude sums wrap at 2^15.

`timescale 1ns/1ps
`default_nettype none

module piir_mac (
  input  logic             clk,
  input  logic             rst,
  input  logic             ce,
  input  logic             cfg,    // config aborts any run
  input  logic             start,
  input  piir_pkg::coef_t  coef,
  input  piir_pkg::hist_t  hist,
  output piir_pkg::sm_t    acc,
  output logic             done
);

  logic [$clog2(piir_pkg::mac_steps)-1:0] step;  // which product term
  logic                                   busy;
  piir_pkg::sm_t                          c_op, h_op;  // current operand pair
  piir_pkg::sm_t                          prod, sum;

  // product keeps bits 29:15, sign is xor of signs
  function automatic piir_pkg::sm_t sm_mul(input piir_pkg::sm_t a, input piir_pkg::sm_t b);
    logic [2*piir_pkg::mag_w-1:0] full;
    full         = a.mag * b.mag;
    sm_mul.sign  = a.sign ^ b.sign;
    sm_mul.mag   = full[2*piir_pkg::mag_w-1:piir_pkg::mag_w];
  endfunction

  // like signs add, unlike signs subtract smaller from larger
  function automatic piir_pkg::sm_t sm_add(input piir_pkg::sm_t a, input piir_pkg::sm_t b);
    piir_pkg::sm_t r;
    if (a.sign == b.sign) begin
      r.sign = a.sign;
      r.mag  = a.mag + b.mag;   // wraps, no saturation
    end else if (a.mag > b.mag) begin
      r.sign = a.sign;
      r.mag  = a.mag - b.mag;
    end else if (b.mag > a.mag) begin
      r.sign = b.sign;
      r.mag  = b.mag - a.mag;
    end else begin
      r = '0;                   // exact cancel -> +0
    end
    return r;
  endfunction

  // operand mux
  always_comb begin
    case (step)
      3'd0:    begin c_op = coef.a1; h_op = hist.y1; end
      3'd1:    begin c_op = coef.a2; h_op = hist.y2; end
      3'd2:    begin c_op = coef.b1; h_op = hist.x1; end
      3'd3:    begin c_op = coef.b2; h_op = hist.x2; end
      default: begin c_op = coef.b0; h_op = hist.x;  end
    endcase
  end

  assign prod = sm_mul(c_op, h_op);
  assign sum  = sm_add(acc, prod);

  always_ff @(posedge clk) begin
    if (rst || (ce && cfg)) begin
      step <= '0;
      busy <= 1'b0;
      done <= 1'b0;
      acc  <= '0;
    end else if (ce) begin
      done <= 1'b0;
      if (start) begin
        step <= '0;
        busy <= 1'b1;
        acc  <= '0;                // start from +0
      end else if (busy) begin
        acc <= sum;
        if (int'(step) == piir_pkg::mac_steps - 1) begin
          busy <= 1'b0;
          done <= 1'b1;            // result settles this edge
          step <= '0;
        end else begin
          step <= step + 1'b1;
        end
      end
    end
  end

  // FSM only restarts the MAC once the previous run is over
  a_start_idle : assert property (
    @(posedge clk) disable iff (rst)
    (ce && start) |-> !busy
  ) else $error("mac start while busy");

  // register file must not move the operands under a running MAC
  a_operands_hold : assert property (
    @(posedge clk) disable iff (rst)
    (ce && busy && !cfg) |=> ($stable(coef) && $stable(hist))
  ) else $error("mac operands changed during a run");

endmodule

`default_nettype wire

//--- verilog/piir_pkg.sv
// Shared types and constants for the biquad IIR filter peripheral.
// Samples are 16-bit sign-magnitude: one sign bit over a Q0.15 fraction.
// Every block refers to these by scoped names (piir_pkg::name).
// Coefficient and history sets travel between blocks as packed structs.

`default_nettype none

package piir_pkg;

  // widths
  localparam int data_w    = 16;          // bus and sample width
  localparam int mag_w     = data_w - 1;  // magnitude bits, also the fraction shift
  localparam int mac_steps = 5;           // product terms per output

  // sign-magnitude sample, sign on top
  typedef struct packed {
    logic             sign;  // 1 = negative
    logic [mag_w-1:0] mag;   // Q0.15 magnitude
  } sm_t;

  // config select codes on cfg_sel
  // gaps in the code space load nothing
  typedef enum logic [3:0] {
    sel_a1  = 4'd1,
    sel_a2  = 4'd2,
    sel_y1  = 4'd5,
    sel_y2  = 4'd6,
    sel_b0  = 4'd8,
    sel_b1  = 4'd9,
    sel_b2  = 4'd10,
    sel_x   = 4'd12,
    sel_x1  = 4'd13,
    sel_x2  = 4'd14,
    sel_dev = 4'd15
  } cfg_sel_e;

  // filter coefficients
  // a1/a2 are held with the sign already flipped,
  // so the feedback terms subtract through a plain add
  typedef struct packed {
    sm_t a1;  // feedback, z^-1
    sm_t a2;  // feedback, z^-2
    sm_t b0;  // feedforward, current sample
    sm_t b1;  // feedforward, z^-1
    sm_t b2;  // feedforward, z^-2
  } coef_t;

  // input and output history
  typedef struct packed {
    sm_t x;   // current sample
    sm_t x1;  // previous sample
    sm_t x2;  // sample before that
    sm_t y1;  // previous output
    sm_t y2;  // output before that
  } hist_t;

  // frame FSM, run order ale -> read -> math -> write
  typedef enum logic [2:0] {
    cfg_st   = 3'd0,  // configure, no bus traffic
    ale_st   = 3'd1,  // device address out
    read_st  = 3'd2,  // sample in
    math_st  = 3'd3,  // MAC running
    write_st = 3'd4,  // result out
    pause_st = 3'd5   // parked between frames
  } frame_state_e;

endpackage

`default_nettype wire

//--- verilog/piir_regs.sv
// Register file of the biquad filter.
// In configure mode (cfg high) the value on ad_in is written into the
// field picked by cfg_sel; feedback coefficients get their sign flipped here.
// In run mode a one-cycle shift pulse from the frame FSM pushes the new
// sample and the last output into the history.

`timescale 1ns/1ps
`default_nettype none

module piir_regs (
  input  logic                clk,
  input  logic                rst,
  input  logic                ce,        // global stall when low
  input  logic                cfg,
  input  piir_pkg::cfg_sel_e  cfg_sel,
  input  piir_pkg::sm_t       ad_in,
  input  logic                shift,     // history push, read cycle
  input  piir_pkg::sm_t       y,         // latest filter output
  output piir_pkg::coef_t     coef,
  output piir_pkg::hist_t     hist,
  output piir_pkg::sm_t       dev_addr
);

  always_ff @(posedge clk) begin
    if (rst) begin
      coef     <= '0;
      hist     <= '0;
      dev_addr <= '0;
    end else if (ce) begin
      if (cfg) begin
        // one field per cycle, everything else holds
        case (cfg_sel)
          piir_pkg::sel_a1: begin
            coef.a1.sign <= ~ad_in.sign;  // stored negated
            coef.a1.mag  <= ad_in.mag;
          end
          piir_pkg::sel_a2: begin
            coef.a2.sign <= ~ad_in.sign;  // stored negated
            coef.a2.mag  <= ad_in.mag;
          end
          piir_pkg::sel_y1:  hist.y1  <= ad_in;
          piir_pkg::sel_y2:  hist.y2  <= ad_in;
          piir_pkg::sel_b0:  coef.b0  <= ad_in;
          piir_pkg::sel_b1:  coef.b1  <= ad_in;
          piir_pkg::sel_b2:  coef.b2  <= ad_in;
          piir_pkg::sel_x:   hist.x   <= ad_in;
          piir_pkg::sel_x1:  hist.x1  <= ad_in;
          piir_pkg::sel_x2:  hist.x2  <= ad_in;
          piir_pkg::sel_dev: dev_addr <= ad_in;
          default: ;                       // unused codes, no write
        endcase
      end else if (shift) begin
        // delay lines move one step
        hist.x  <= ad_in;    // sample on the bus this cycle
        hist.x1 <= hist.x;
        hist.x2 <= hist.x1;
        hist.y1 <= y;        // output of the frame just finished
        hist.y2 <= hist.y1;
      end
    end
  end

  // frame FSM drops all strobes on the edge after cfg is seen,
  // so no history push may follow a cfg cycle
  a_no_shift_after_cfg : assert property (
    @(posedge clk) disable iff (rst)
    (ce && cfg) |=> !shift
  ) else $error("history shift right after a config cycle");

endmodule

`default_nettype wire

//--- verilog/piir_top.sv
// Top level of the biquad IIR filter peripheral.
// cfg high: cfg_sel/ad_in write the register file.
// cfg low: frames of ale (address out), rd (sample in), five MAC steps,
// wr (result out). ad_out is zero whenever no output strobe is high.

`timescale 1ns/1ps
`default_nettype none

module piir_top (
  input  logic           clk,
  input  logic           rst,
  input  logic           ce,
  input  logic           cfg,
  input  logic           pu,
  input  logic [3:0]     cfg_sel,
  input  piir_pkg::sm_t  ad_in,
  output piir_pkg::sm_t  ad_out,
  output logic           ale,
  output logic           rd,
  output logic           wr
);

  piir_pkg::coef_t coef;
  piir_pkg::hist_t hist;
  piir_pkg::sm_t   dev_addr, y, acc;
  logic            shift, mac_start, mac_done;

  piir_regs regs_i (
    .clk(clk), .rst(rst), .ce(ce), .cfg(cfg),
    .cfg_sel(piir_pkg::cfg_sel_e'(cfg_sel)),  // raw code, gaps decode to nothing
    .ad_in(ad_in), .shift(shift), .y(y),
    .coef(coef), .hist(hist), .dev_addr(dev_addr)
  );

  piir_mac mac_i (
    .clk(clk), .rst(rst), .ce(ce), .cfg(cfg), .start(mac_start),
    .coef(coef), .hist(hist), .acc(acc), .done(mac_done)
  );

  piir_ctrl ctrl_i (
    .clk(clk), .rst(rst), .ce(ce), .cfg(cfg), .pu(pu),
    .mac_done(mac_done), .acc(acc),
    .ale(ale), .rd(rd), .wr(wr), .shift(shift), .mac_start(mac_start), .y(y)
  );

  // address on ale, result on wr, otherwise idle low
  assign ad_out = ale ? dev_addr : (wr ? y : '0);

endmodule

`default_nettype wire
